// File: Makefile
TOP = fetch_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f strand_fetch.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: branch_predecoder.sv
/*
 * Combinational pre-decode of a word returned by the instruction cache: byte swap,
 * static branch prediction with its target offset, and the long-latency flag
 */
`timescale 1ns/1ps

module branch_predecoder (
	input  logic [fetch_pkg::WORD_WIDTH-1:0] icache_data_i,
	output logic [fetch_pkg::WORD_WIDTH-1:0] instruction_o,
	output logic                             branch_predicted_o,
	output logic [fetch_pkg::WORD_WIDTH-1:0] branch_offset_o,
	output logic                             long_latency_o
);

	localparam int W = fetch_pkg::WORD_WIDTH;

	logic is_cond_branch;

	// The cache returns words little-endian, the decoder wants them big-endian
	always_comb
	begin
		for (int b = 0; b < W / 8; b++)
			instruction_o[b * 8 +: 8] = icache_data_i[W - 8 - b * 8 +: 8];
	end

	// Conditional branches share the branch nibble and use one of four subtypes
	always_comb
	begin
		is_cond_branch = 1'b0;
		if (instruction_o[31:28] == fetch_pkg::BR_NIBBLE)
			for (int c = 0; c < fetch_pkg::NUM_COND_CODES; c++)
				if (instruction_o[27:25] == fetch_pkg::BR_COND_CODES[c])
					is_cond_branch = 1'b1;
	end

	// 20-bit signed offset in bits 24:5, relative to the following instruction
	assign branch_offset_o = {{(W - 20){instruction_o[24]}}, instruction_o[24:5]};

	// Unconditional branches and calls are always taken
	// Conditional ones are guessed taken when they jump backwards, as loops do
	assign branch_predicted_o = instruction_o[31:25] == fetch_pkg::BR_ALWAYS
		|| instruction_o[31:25] == fetch_pkg::BR_CALL
		|| (is_cond_branch && branch_offset_o[W-1]);

	// Multiplies go to the longer arithmetic pipeline
	always_comb
	begin
		if (instruction_o[31:29] == fetch_pkg::FORMAT_A_TAG)
		begin
			// Format A with bit 25 set selects the long pipeline for any opcode
			long_latency_o = instruction_o[25]
				|| instruction_o[25:20] == fetch_pkg::OP_IMUL;
		end
		else if (!instruction_o[31])
		begin
			// Format B has a five-bit opcode field
			long_latency_o = instruction_o[27:23] == fetch_pkg::OP_IMUL[4:0];
		end
		else
			long_latency_o = 1'b0;
	end

endmodule

// File: fetch_pkg.sv
/*
 * Shared constants of the fetch stage: word width, opcode and branch encodings,
 * and the layout width of one instruction FIFO entry
 */
package fetch_pkg;

	// Instruction and address width
	localparam int WORD_WIDTH = 32;

	// Integer multiply opcode, which goes down the long-latency arithmetic pipeline
	// Format B only has room for the low five bits of it
	localparam logic [5:0] OP_IMUL = 6'b000111;

	// Top seven bits of the unconditional branch and call encodings
	localparam logic [6:0] BR_ALWAYS = 7'b1111_011;
	localparam logic [6:0] BR_CALL = 7'b1111_100;

	// Top nibble shared by all branch encodings
	localparam logic [3:0] BR_NIBBLE = 4'b1111;

	// Conditional branch subtypes in bits 27:25 below the branch nibble
	localparam int NUM_COND_CODES = 4;
	localparam logic [NUM_COND_CODES-1:0][2:0] BR_COND_CODES = {
		3'b101,
		3'b010,
		3'b001,
		3'b000
	};

	// Tag in bits 31:29 of a format A arithmetic instruction
	localparam logic [2:0] FORMAT_A_TAG = 3'b110;

	// One FIFO entry holds the next PC, the instruction, the predicted flag and
	// the long-latency flag, packed in that order from the top bit down
	localparam int FIFO_ENTRY_WIDTH = 2 * WORD_WIDTH + 2;

endpackage

// File: fetch_tb.sv
/*
 * Randomized testbench of the fetch stage; models the instruction cache, the strand
 * select stage and the rollback controller and checks every dequeued entry and request
 */
`timescale 1ns/1ps

module fetch_tb;

	localparam int NUM_STRANDS = 4;
	localparam int FIFO_DEPTH = 4;
	localparam int IDX_W = $clog2(NUM_STRANDS);
	localparam int NUM_CYCLES = 4000;
	localparam int CLK_PERIOD = 8;
	localparam int MEM_WORDS = 256;
	localparam int MODEL_CAP = 8;

	logic                      clk;
	logic                      reset;
	logic                      icache_request;
	logic [31:0]               icache_addr;
	logic [IDX_W-1:0]          icache_req_strand;
	logic                      icache_hit;
	logic [31:0]               icache_data;
	logic                      icache_load_collision;
	logic [NUM_STRANDS-1:0]    icache_load_complete;
	logic [NUM_STRANDS-1:0]    if_valid;
	logic [NUM_STRANDS*32-1:0] if_instruction;
	logic [NUM_STRANDS*32-1:0] if_pc;
	logic [NUM_STRANDS-1:0]    if_branch_predicted;
	logic [NUM_STRANDS-1:0]    if_long_latency;
	logic [NUM_STRANDS-1:0]    ss_instruction_req;
	logic [NUM_STRANDS-1:0]    rb_rollback;
	logic [NUM_STRANDS*32-1:0] rb_rollback_pc;

	// Cache contents in big-endian form, indexed by address bits 9:2
	logic [31:0] mem [MEM_WORDS];

	// Reference model: expected fetch address and queued entries per strand
	logic [31:0]            exp_pc [NUM_STRANDS];
	logic [65:0]            model_q [NUM_STRANDS][MODEL_CAP];
	int                     q_head [NUM_STRANDS];
	int                     q_count [NUM_STRANDS];
	logic [NUM_STRANDS-1:0] waiting;
	int                     miss_timer [NUM_STRANDS];

	// Request seen in the previous cycle, answered by the cache in this one
	logic             prev_req;
	logic [IDX_W-1:0] prev_strand;
	logic [31:0]      prev_addr;

	integer seed;
	int     errors;
	int     checks;
	int     dequeued;

	tb_clock_gen #(
		.PERIOD(CLK_PERIOD)
	) u_clock (
		.clk_o(clk)
	);

	instruction_fetch_stage #(
		.NUM_STRANDS(NUM_STRANDS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut (
		.clk(clk),
		.reset(reset),
		.icache_request_o(icache_request),
		.icache_addr_o(icache_addr),
		.icache_req_strand_o(icache_req_strand),
		.icache_hit_i(icache_hit),
		.icache_data_i(icache_data),
		.icache_load_collision_i(icache_load_collision),
		.icache_load_complete_i(icache_load_complete),
		.if_valid_o(if_valid),
		.if_instruction_o(if_instruction),
		.if_pc_o(if_pc),
		.if_branch_predicted_o(if_branch_predicted),
		.if_long_latency_o(if_long_latency),
		.ss_instruction_req_i(ss_instruction_req),
		.rb_rollback_i(rb_rollback),
		.rb_rollback_pc_i(rb_rollback_pc)
	);

	// The cache bus carries words little-endian
	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Sign-extended offset field of bits 24:5
	function automatic logic [31:0] offset_of(input logic [31:0] w);
		return {{12{w[24]}}, w[24:5]};
	endfunction

	// Branch-always (1111011) and call (1111100) are taken, conditionals only backwards
	function automatic logic predict_taken(input logic [31:0] w);
		logic cond;
		cond = 1'b0;
		if (w[31:28] == 4'hf)
		begin
			case (w[27:25])
				3'd0, 3'd1, 3'd2, 3'd5: cond = 1'b1;
				default: cond = 1'b0;
			endcase
		end
		return w[31:25] == 7'h7b || w[31:25] == 7'h7c || (cond && w[24]);
	endfunction

	// Format A is tag 110, format B is anything with bit 31 clear
	function automatic logic is_long_latency(input logic [31:0] w);
		case (w[31:29])
			3'b110: return w[25] || w[25:20] == 6'd7;
			3'b000, 3'b001, 3'b010, 3'b011: return w[27:23] == 5'd7;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_equal(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h at %0t ns",
				name, expected, actual, $time);
		end
	endtask

	// Mix of branches, calls, conditionals, multiplies and plain words
	task automatic fill_memory();
		int          kind;
		int          off;
		logic [31:0] r;
		logic [2:0]  code;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			kind = {$random(seed)} % 8;
			r = $random(seed);
			// Up to 63 words either way, kept word aligned
			off = ($random(seed) % 64) * 4;
			case (r[1:0])
				2'd0: code = 3'd0;
				2'd1: code = 3'd1;
				2'd2: code = 3'd2;
				default: code = 3'd5;
			endcase
			case (kind)
				0: mem[i] = {7'h7b, off[19:0], r[4:0]};
				1: mem[i] = {7'h7c, off[19:0], r[4:0]};
				2: mem[i] = {4'hf, code, off[19:0], r[4:0]};
				3: mem[i] = {3'b110, r[28:0]};
				4: mem[i] = {1'b0, r[30:28], 5'd7, r[22:0]};
				default: mem[i] = {r[31:7], 2'b00, r[4:0]};
			endcase
		end
	endtask

	task automatic push_entry(input int s, input logic [65:0] entry);
		if (q_count[s] == MODEL_CAP)
		begin
			errors++;
			$display("Model queue of strand %0d overflowed at %0t ns", s, $time);
		end
		else
		begin
			model_q[s][(q_head[s] + q_count[s]) % MODEL_CAP] = entry;
			q_count[s]++;
		end
	endtask

	// Phase 0 is all hits, phase 2 holds the consumer off, the rest mixes everything
	task automatic drive_inputs(input int cyc);
		int phase;
		int pick;
		int s;
		phase = (cyc / 250) % 4;
		icache_load_complete = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			if (miss_timer[i] > 0)
			begin
				miss_timer[i]--;
				if (miss_timer[i] == 0)
					icache_load_complete[i] = 1'b1;
			end
		end
		icache_hit = 1'b0;
		icache_load_collision = 1'b0;
		icache_data = '0;
		if (prev_req)
		begin
			icache_data = swap_bytes(mem[prev_addr[9:2]]);
			pick = {$random(seed)} % 100;
			if (phase == 0 || pick < 70)
				icache_hit = 1'b1;
			else if (pick < 85)
				icache_load_collision = 1'b1;
			else
				miss_timer[prev_strand] = 2 + {$random(seed)} % 9;
		end
		for (int i = 0; i < NUM_STRANDS; i++)
			ss_instruction_req[i] = phase != 2 && {$random(seed)} % 4 != 0;
		rb_rollback = '0;
		if (phase != 0 && {$random(seed)} % 40 == 0)
		begin
			s = {$random(seed)} % NUM_STRANDS;
			rb_rollback[s] = 1'b1;
			rb_rollback_pc[s * 32 +: 32] = 32'(4 * (1 + {$random(seed)} % (MEM_WORDS - 1)));
		end
	endtask

	// Mirrors what the next clock edge does and checks the outputs of this cycle
	task automatic update_model();
		logic [31:0]            word;
		logic [65:0]            entry;
		logic [NUM_STRANDS-1:0] pushed;
		int                     size_before [NUM_STRANDS];
		int                     p;
		int                     s;
		waiting = waiting & ~icache_load_complete;
		// Consumer side sees the queues as they stood before this edge
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			size_before[i] = q_count[i];
			check_equal($sformatf("if_valid strand %0d", i), 64'(q_count[i] != 0),
				64'(if_valid[i]));
			if (ss_instruction_req[i] && if_valid[i] && q_count[i] != 0)
			begin
				entry = model_q[i][q_head[i]];
				q_head[i] = (q_head[i] + 1) % MODEL_CAP;
				q_count[i]--;
				dequeued++;
				check_equal($sformatf("if_pc strand %0d", i), 64'(entry[65:34]),
					64'(if_pc[i * 32 +: 32]));
				check_equal($sformatf("if_instruction strand %0d", i), 64'(entry[33:2]),
					64'(if_instruction[i * 32 +: 32]));
				check_equal($sformatf("if_branch_predicted strand %0d", i), 64'(entry[1]),
					64'(if_branch_predicted[i]));
				check_equal($sformatf("if_long_latency strand %0d", i), 64'(entry[0]),
					64'(if_long_latency[i]));
			end
		end
		// Response to last cycle's request
		pushed = '0;
		if (prev_req)
		begin
			p = int'(prev_strand);
			if (icache_hit)
			begin
				// The queue still takes the slot even if a flush drops the entry
				pushed[p] = 1'b1;
				word = mem[exp_pc[p][9:2]];
				entry = {exp_pc[p] + 32'd4, word, predict_taken(word), is_long_latency(word)};
				if (!rb_rollback[p])
					push_entry(p, entry);
				if (predict_taken(word))
					exp_pc[p] = exp_pc[p] + 32'd4 + offset_of(word);
				else
					exp_pc[p] = exp_pc[p] + 32'd4;
			end
			else if (!icache_load_collision)
				waiting[p] = 1'b1;
		end
		// A rollback flushes the queue and wins over a same-cycle hit
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			if (rb_rollback[i])
			begin
				q_count[i] = 0;
				q_head[i] = 0;
				exp_pc[i] = rb_rollback_pc[i * 32 +: 32];
			end
		end
		if (icache_request)
		begin
			s = int'(icache_req_strand);
			check_equal($sformatf("parked strand %0d requested", s), 64'(0), 64'(waiting[s]));
			check_equal($sformatf("fetch address strand %0d", s), 64'(exp_pc[s]),
				64'(icache_addr));
			if (size_before[s] + int'(pushed[s]) >= FIFO_DEPTH)
			begin
				errors++;
				$display("Strand %0d was requested with no room left in its queue at %0t ns",
					s, $time);
			end
		end
		prev_req = icache_request;
		prev_strand = icache_req_strand;
		prev_addr = icache_addr;
	endtask

	initial
	begin
		seed = 74093;
		errors = 0;
		checks = 0;
		dequeued = 0;
		reset = 1'b1;
		icache_hit = 1'b0;
		icache_data = '0;
		icache_load_collision = 1'b0;
		icache_load_complete = '0;
		ss_instruction_req = '0;
		rb_rollback = '0;
		rb_rollback_pc = '0;
		waiting = '0;
		prev_req = 1'b0;
		prev_strand = '0;
		prev_addr = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			exp_pc[i] = '0;
			q_head[i] = 0;
			q_count[i] = 0;
			miss_timer[i] = 0;
		end
		fill_memory();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_equal("if_valid after reset", 64'(0), 64'(if_valid));
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
		begin
			drive_inputs(cyc);
			#1;
			update_model();
			@(negedge clk);
		end
		// A stalled pipeline would pass every check, so demand some progress
		if (dequeued < NUM_CYCLES / 4)
		begin
			errors++;
			$display("Only %0d instructions were delivered in %0d cycles", dequeued, NUM_CYCLES);
		end
		$display("%0d checks, %0d errors, %0d entries dequeued", checks, errors, dequeued);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Twice the nominal run time
	initial
	begin
		#(NUM_CYCLES * CLK_PERIOD * 2);
		$display("Timeout: the run did not finish within %0d ns", NUM_CYCLES * CLK_PERIOD * 2);
		$display("sim failed");
		$finish;
	end

endmodule

// File: icache_request_unit.sv
/*
 * Picks one strand per cycle to fetch from the instruction cache and keeps track
 * of strands that are parked on a cache miss until the cache reports the fill
 */
`timescale 1ns/1ps

module icache_request_unit #(
	parameter int NUM_STRANDS = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [NUM_STRANDS-1:0] eligible_i,
	input  logic                   icache_hit_i,
	input  logic                   icache_load_collision_i,
	input  logic [NUM_STRANDS-1:0] icache_load_complete_i,
	output logic [NUM_STRANDS-1:0] grant_oh_o,
	output logic [NUM_STRANDS-1:0] last_oh_o,
	output logic                   request_o,
	output logic [(NUM_STRANDS > 1 ? $clog2(NUM_STRANDS) : 1)-1:0] req_strand_o
);

	localparam int IDX_W = (NUM_STRANDS > 1) ? $clog2(NUM_STRANDS) : 1;

	logic [NUM_STRANDS-1:0] wait_q;
	logic [NUM_STRANDS-1:0] wait_nxt;
	logic [NUM_STRANDS-1:0] candidates;
	logic [IDX_W-1:0]       last_idx_q;
	logic                   miss;
	logic                   found;
	int                     cand;

	// The cache answers for the strand granted last cycle, so a response that is
	// neither a hit nor a collision is a miss for that strand
	assign miss = (last_oh_o != '0) && !icache_hit_i && !icache_load_collision_i;

	// A fill completing this cycle releases its strand right away, while a miss
	// reported this cycle already keeps its strand out of arbitration
	always_comb
	begin
		wait_nxt = wait_q & ~icache_load_complete_i;
		if (miss)
			wait_nxt = wait_nxt | last_oh_o;
	end

	assign candidates = eligible_i & ~wait_nxt;

	// Rotating priority that starts just past the strand granted most recently,
	// so the strand that waited longest since its last grant wins
	always_comb
	begin
		grant_oh_o = '0;
		found = 1'b0;
		cand = 0;
		for (int off = 1; off <= NUM_STRANDS; off++)
		begin
			cand = (int'(last_idx_q) + off) % NUM_STRANDS;
			if (!found && candidates[cand])
			begin
				grant_oh_o[cand] = 1'b1;
				found = 1'b1;
			end
		end
	end

	assign request_o = grant_oh_o != '0;

	// Index of the granted strand for the cache and the address mux
	always_comb
	begin
		req_strand_o = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
			if (grant_oh_o[i])
				req_strand_o = i[IDX_W-1:0];
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wait_q <= '0;
			last_oh_o <= '0;
			last_idx_q <= '0;
		end
		else
		begin
			wait_q <= wait_nxt;
			last_oh_o <= grant_oh_o;
			// The priority pointer only moves when something was granted
			if (request_o)
				last_idx_q <= req_strand_o;
		end
	end

	// At most one strand talks to the cache per cycle
	assert property (@(posedge clk) disable iff (reset) $onehot0(grant_oh_o));

	// The cache only reports a completed fill for a strand parked on a miss
	assert property (@(posedge clk) disable iff (reset)
		(icache_load_complete_i & ~wait_q) == '0);

endmodule

// File: instruction_fetch_stage.sv
/*
 * Fetch stage of the barrel-threaded core: requests instructions for one strand
 * per cycle and keeps a small pre-decoded instruction queue for every strand
 */
`timescale 1ns/1ps

module instruction_fetch_stage #(
	parameter int NUM_STRANDS = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                          clk,
	input  logic                                          reset,

	// Instruction cache
	output logic                                          icache_request_o,
	output logic [fetch_pkg::WORD_WIDTH-1:0]              icache_addr_o,
	output logic [(NUM_STRANDS > 1 ? $clog2(NUM_STRANDS) : 1)-1:0] icache_req_strand_o,
	input  logic                                          icache_hit_i,
	input  logic [fetch_pkg::WORD_WIDTH-1:0]              icache_data_i,
	input  logic                                          icache_load_collision_i,
	input  logic [NUM_STRANDS-1:0]                        icache_load_complete_i,

	// Strand select stage, one lane per strand on every flat bus
	output logic [NUM_STRANDS-1:0]                        if_valid_o,
	output logic [NUM_STRANDS*fetch_pkg::WORD_WIDTH-1:0]  if_instruction_o,
	output logic [NUM_STRANDS*fetch_pkg::WORD_WIDTH-1:0]  if_pc_o,
	output logic [NUM_STRANDS-1:0]                        if_branch_predicted_o,
	output logic [NUM_STRANDS-1:0]                        if_long_latency_o,
	input  logic [NUM_STRANDS-1:0]                        ss_instruction_req_i,

	// Rollback controller
	input  logic [NUM_STRANDS-1:0]                        rb_rollback_i,
	input  logic [NUM_STRANDS*fetch_pkg::WORD_WIDTH-1:0]  rb_rollback_pc_i
);

	localparam int W = fetch_pkg::WORD_WIDTH;

	logic [NUM_STRANDS-1:0]   last_oh;
	logic [NUM_STRANDS-1:0]   eligible;
	logic [NUM_STRANDS-1:0]   fifo_full;
	logic [NUM_STRANDS-1:0]   fifo_almost_full;
	logic [NUM_STRANDS-1:0]   fifo_empty;
	logic [NUM_STRANDS-1:0]   fifo_enqueue;
	logic [NUM_STRANDS*W-1:0] pc_cur;
	logic [NUM_STRANDS*W-1:0] pc_next;
	logic [W-1:0]             instruction;
	logic [W-1:0]             branch_offset;
	logic                     branch_predicted;
	logic                     long_latency;

	// A hit always belongs to the strand that requested in the previous cycle
	assign fifo_enqueue = {NUM_STRANDS{icache_hit_i}} & last_oh;

	// A strand whose queue is about to take its last free slot this cycle must
	// not request again, or that response would have nowhere to go
	assign eligible = ~fifo_full & ~(fifo_almost_full & fifo_enqueue);

	assign if_valid_o = ~fifo_empty;

	// The requested address already reflects a hit or rollback in this cycle
	assign icache_addr_o = pc_next[icache_req_strand_o * W +: W];

	icache_request_unit #(
		.NUM_STRANDS(NUM_STRANDS)
	) u_request (
		.clk(clk),
		.reset(reset),
		.eligible_i(eligible),
		.icache_hit_i(icache_hit_i),
		.icache_load_collision_i(icache_load_collision_i),
		.icache_load_complete_i(icache_load_complete_i),
		.grant_oh_o(),
		.last_oh_o(last_oh),
		.request_o(icache_request_o),
		.req_strand_o(icache_req_strand_o)
	);

	branch_predecoder u_predecode (
		.icache_data_i(icache_data_i),
		.instruction_o(instruction),
		.branch_predicted_o(branch_predicted),
		.branch_offset_o(branch_offset),
		.long_latency_o(long_latency)
	);

	strand_pc_file #(
		.NUM_STRANDS(NUM_STRANDS)
	) u_pc_file (
		.clk(clk),
		.reset(reset),
		.last_oh_i(last_oh),
		.icache_hit_i(icache_hit_i),
		.branch_predicted_i(branch_predicted),
		.branch_offset_i(branch_offset),
		.rollback_i(rb_rollback_i),
		.rollback_pc_i(rb_rollback_pc_i),
		.pc_cur_o(pc_cur),
		.pc_next_o(pc_next)
	);

	genvar s;

	generate
		for (s = 0; s < NUM_STRANDS; s++)
		begin : g_strand
			logic [fetch_pkg::FIFO_ENTRY_WIDTH-1:0] entry_in;
			logic [fetch_pkg::FIFO_ENTRY_WIDTH-1:0] entry_out;

			// The reported PC is the one after the fetched instruction
			assign entry_in = {pc_cur[s * W +: W] + W'(4), instruction,
				branch_predicted, long_latency};

			sync_fifo #(
				.WIDTH(fetch_pkg::FIFO_ENTRY_WIDTH),
				.DEPTH(FIFO_DEPTH)
			) u_fifo (
				.clk(clk),
				.reset(reset),
				.flush_i(rb_rollback_i[s]),
				.enqueue_i(fifo_enqueue[s]),
				.value_i(entry_in),
				.dequeue_i(ss_instruction_req_i[s] && if_valid_o[s]),
				.value_o(entry_out),
				.full_o(fifo_full[s]),
				.almost_full_o(fifo_almost_full[s]),
				.empty_o(fifo_empty[s])
			);

			assign if_pc_o[s * W +: W] = entry_out[2 * W + 1 -: W];
			assign if_instruction_o[s * W +: W] = entry_out[W + 1 -: W];
			assign if_branch_predicted_o[s] = entry_out[1];
			assign if_long_latency_o[s] = entry_out[0];
		end
	endgenerate

endmodule

// File: strand_fetch.f
fetch_pkg.sv
sync_fifo.sv
icache_request_unit.sv
branch_predecoder.sv
strand_pc_file.sv
instruction_fetch_stage.sv
tb_clock_gen.sv
fetch_tb.sv

// File: strand_pc_file.sv
/*
 * Program counters of all strands, advanced on a cache hit, held otherwise, and
 * loaded from the rollback controller when a strand is redirected
 */
`timescale 1ns/1ps

module strand_pc_file #(
	parameter int NUM_STRANDS = 4
) (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic [NUM_STRANDS-1:0]                        last_oh_i,
	input  logic                                          icache_hit_i,
	input  logic                                          branch_predicted_i,
	input  logic [fetch_pkg::WORD_WIDTH-1:0]              branch_offset_i,
	input  logic [NUM_STRANDS-1:0]                        rollback_i,
	input  logic [NUM_STRANDS*fetch_pkg::WORD_WIDTH-1:0]  rollback_pc_i,
	output logic [NUM_STRANDS*fetch_pkg::WORD_WIDTH-1:0]  pc_cur_o,
	output logic [NUM_STRANDS*fetch_pkg::WORD_WIDTH-1:0]  pc_next_o
);

	localparam int W = fetch_pkg::WORD_WIDTH;

	genvar s;

	generate
		for (s = 0; s < NUM_STRANDS; s++)
		begin : g_strand
			logic [W-1:0] pc_q;
			logic [W-1:0] pc_nxt;
			logic [W-1:0] rollback_pc;

			assign rollback_pc = rollback_pc_i[s * W +: W];

			// On a hit for this strand pc_q is the address just fetched, so the
			// following address is resolved in the same cycle the word returns
			always_comb
			begin
				if (rollback_i[s])
					pc_nxt = rollback_pc;
				else if (!icache_hit_i || !last_oh_i[s])
					pc_nxt = pc_q;
				else if (branch_predicted_i)
					pc_nxt = pc_q + W'(4) + branch_offset_i;
				else
					pc_nxt = pc_q + W'(4);
			end

			always_ff @(posedge clk or posedge reset)
			begin
				if (reset)
					pc_q <= '0;
				else
					pc_q <= pc_nxt;
			end

			assign pc_cur_o[s * W +: W] = pc_q;
			assign pc_next_o[s * W +: W] = pc_nxt;

			// Address zero is where a strand lands after a bad redirect, so a
			// rollback there points at a fault upstream
			assert property (@(posedge clk) disable iff (reset)
				rollback_i[s] |-> rollback_pc != '0);
		end
	endgenerate

endmodule

// File: sync_fifo.sv
/*
 * Single-clock FIFO used as the per-strand instruction queue
 * Flush empties it in one cycle and wins over a same-cycle enqueue
 */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 66,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush_i,
	input  logic             enqueue_i,
	input  logic [WIDTH-1:0] value_i,
	input  logic             dequeue_i,
	output logic [WIDTH-1:0] value_o,
	output logic             full_o,
	output logic             almost_full_o,
	output logic             empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] storage [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign full_o = count == CNT_W'(DEPTH);
	// One free slot left
	assign almost_full_o = count == CNT_W'(DEPTH - 1);
	assign empty_o = count == '0;
	assign value_o = storage[rd_ptr];

	// Pointer wrap that also works when DEPTH is not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + PTR_W'(1);
	endfunction

	// Write port of the entry array, which a flush blocks
	always_ff @(posedge clk)
	begin
		if (enqueue_i && !flush_i)
			storage[wr_ptr] <= value_i;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue_i)
				wr_ptr <= next_ptr(wr_ptr);
			if (dequeue_i)
				rd_ptr <= next_ptr(rd_ptr);
			if (enqueue_i && !dequeue_i)
				count <= count + CNT_W'(1);
			else if (dequeue_i && !enqueue_i)
				count <= count - CNT_W'(1);
		end
	end

	// The writer must watch the full flag, otherwise an entry is overwritten
	assert property (@(posedge clk) disable iff (reset)
		!(enqueue_i && full_o && !flush_i));

	// The reader must only pop what is there
	assert property (@(posedge clk) disable iff (reset) !(dequeue_i && empty_o));

endmodule

// File: tb_clock_gen.sv
/*
 * Free-running testbench clock, starting low
 */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD = 8
) (
	output logic clk_o
);

	// Half a period per level
	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD / 2) clk_o = ~clk_o;
	end

endmodule
